/* vlog.f */
common/trackPkg.sv
hdl/pixelClassifier.sv
hdl/rasterCounter.sv
windowBank/winAccum.sv
windowBank/windowBank.sv
hdl/trackCtrl.sv
hdl/colorTracker.sv
sim/colorTracker_chk.sv
sim/colorTrackerTb.sv

/* sim/colorTrackerTb.sv */
module colorTrackerTb;

  localparam int FRAME_H       = 32;
  localparam int FRAME_V       = 24;
  localparam int WIN_H         = 4;
  localparam int WIN_V         = 4;
  localparam int STEP_H        = 2;
  localparam int NUM_WIN       = 5;
  localparam int NUM_ROWS      = 3;
  localparam int BLUE_MARGIN   = 40;
  localparam int RED_MARGIN    = 90;
  localparam int RED_COUNT_MIN = 3;
  localparam int SEARCH_H      = STEP_H * (NUM_WIN - 1) + WIN_H;
  localparam int SEARCH_V      = NUM_ROWS * WIN_V;
  localparam int TIMEOUT       = 2000;  // idle cycles allowed for a late result

  localparam logic [23:0] BG_PIX    = 24'h404040;  // grey background
  localparam logic [23:0] BLUE_PIX  = 24'h1020e0;
  localparam logic [23:0] RED_PIX   = 24'he02010;
  localparam logic [23:0] EDGE_BLUE = 24'h303058;  // blue exactly at the margin
  localparam logic [23:0] OVER_BLUE = 24'h303059;  // one step over the margin

  logic             i_clk, i_rst_n;
  logic [23:0]      i_pixel;
  logic             i_pixelValid, i_start, i_hold;
  trackPkg::coord_t o_pointH, o_pointV;
  logic             o_valid, o_isTracking;

  integer      seed = 32'hc9cf596e;
  int          errors;
  int          validCount;     // o_valid pulses since the frame began
  int          gotH, gotV;
  logic        gotTrk;
  int          expOH, expOV;   // region origin the DUT should be using
  logic [23:0] img [FRAME_V][FRAME_H];

  colorTracker #(
    .FRAME_H (FRAME_H), .FRAME_V (FRAME_V), .WIN_H (WIN_H), .WIN_V (WIN_V),
    .STEP_H (STEP_H), .NUM_WIN (NUM_WIN), .NUM_ROWS (NUM_ROWS),
    .BLUE_MARGIN (BLUE_MARGIN), .RED_MARGIN (RED_MARGIN), .RED_COUNT_MIN (RED_COUNT_MIN)
  ) u_dut (
    .i_clk (i_clk), .i_rst_n (i_rst_n), .i_pixel (i_pixel), .i_pixelValid (i_pixelValid),
    .i_start (i_start), .i_hold (i_hold), .o_pointH (o_pointH), .o_pointV (o_pointV),
    .o_valid (o_valid), .o_isTracking (o_isTracking)
  );

  initial begin
    i_clk = 1'b0;
    forever #20 i_clk = ~i_clk;
  end

  // ==========================================================
  // checking and clocking helpers
  // ==========================================================
  task automatic stopRun();
    $display("RESULT: FAIL");
    $fatal(1, "stopped at the first error");
  endtask

  task automatic checkEq(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      errors++;
      $display("ERROR: %s = 0x%0h, expected 0x%0h", name, got, exp);
      stopRun();
    end
  endtask

  // sample the result on the falling edge and park the inputs
  task automatic tick();
    @(negedge i_clk);
    if (o_valid) begin
      validCount++;
      gotH   = o_pointH;
      gotV   = o_pointV;
      gotTrk = o_isTracking;
    end
    i_pixelValid = 1'b0;
    i_start      = 1'b0;
    i_hold       = 1'b0;
  endtask

  // ==========================================================
  // frame drawing
  // ==========================================================
  task automatic clearImage();
    for (int y = 0; y < FRAME_V; y++)
      for (int x = 0; x < FRAME_H; x++)
        img[y][x] = BG_PIX;
  endtask

  task automatic paintRect(input int x0, input int y0, input int w, input int h,
                           input logic [23:0] color);
    for (int y = y0; y < y0 + h; y++)
      for (int x = x0; x < x0 + w; x++)
        img[y][x] = color;
  endtask

  // holdAt is the pixel index carrying i_hold or -1 for none
  task automatic drawFrame(input int holdAt);
    int idx;
    idx = 0;
    validCount = 0;
    for (int y = 0; y < FRAME_V; y++) begin
      for (int x = 0; x < FRAME_H; x++) begin
        if (($random(seed) & 15) == 0)
          tick();  // gap in the stream
        tick();
        i_pixel      = img[y][x];
        i_pixelValid = 1'b1;
        i_hold       = (idx == holdAt);
        idx++;
      end
    end
    tick();
  endtask

  task automatic waitResult();
    int n;
    n = 0;
    while (validCount == 0 && n < TIMEOUT) begin
      tick();
      n++;
    end
    if (validCount == 0) begin
      errors++;
      $display("timeout: no o_valid within %0d cycles after the frame", TIMEOUT);
      stopRun();
    end else if (validCount > 1) begin
      errors++;
      $display("more than one o_valid pulse seen for a single region");
      stopRun();
    end
  endtask

  // ==========================================================
  // reference model
  // ==========================================================
  function automatic logic isBluePix(input logic [23:0] p);
    int r, g, b;
    r = p[23:16];
    g = p[15:8];
    b = p[7:0];
    return (b - r > BLUE_MARGIN) && (b - g > BLUE_MARGIN);
  endfunction

  function automatic logic isRedPix(input logic [23:0] p);
    int r, g, b;
    r = p[23:16];
    g = p[15:8];
    b = p[7:0];
    return (r - b > RED_MARGIN) && (r - g > RED_MARGIN);
  endfunction

  function automatic int clampPos(input int best, input int region, input int win,
                                  input int frame);
    int pos;
    pos = best - (region - win) / 2;
    if (pos < 0)
      pos = 0;
    if (pos > frame - region)
      pos = frame - region;
    return pos;
  endfunction

  // windows finish row by row and left to right
  task automatic modelRegion(output int bestH, output int bestV, output logic trk);
    int   sH, sV, nBlue, nRed, bestSum;
    logic first, anyRed;
    first   = 1'b1;
    anyRed  = 1'b0;
    bestSum = 0;
    bestH   = 0;
    bestV   = 0;
    for (int r = 0; r < NUM_ROWS; r++) begin
      for (int k = 0; k < NUM_WIN; k++) begin
        sH    = expOH + k * STEP_H;
        sV    = expOV + r * WIN_V;
        nBlue = 0;
        nRed  = 0;
        for (int y = sV; y < sV + WIN_V; y++) begin
          for (int x = sH; x < sH + WIN_H; x++) begin
            if (isBluePix(img[y][x]))
              nBlue++;
            else if (isRedPix(img[y][x]))
              nRed++;
          end
        end
        if (first || nBlue > bestSum) begin  // only a larger sum wins
          bestH   = sH;
          bestV   = sV;
          bestSum = nBlue;
          first   = 1'b0;
        end
        if (nRed > RED_COUNT_MIN)
          anyRed = 1'b1;
      end
    end
    trk = !anyRed;
  endtask

  // one searched frame checked against the model before recentring
  task automatic runSearch();
    int   expH, expV;
    logic expTrk;
    modelRegion(expH, expV, expTrk);
    drawFrame(-1);
    waitResult();
    checkEq("o_pointH", gotH, expH);
    checkEq("o_pointV", gotV, expV);
    checkEq("o_isTracking", gotTrk, expTrk);
    expOH = clampPos(expH, SEARCH_H, WIN_H, FRAME_H);
    expOV = clampPos(expV, SEARCH_V, WIN_V, FRAME_V);
  endtask

  // ==========================================================
  // directed tests
  // ==========================================================
  task automatic resetAndIdle();
    checkEq("o_valid", o_valid, 0);
    checkEq("o_isTracking", o_isTracking, 0);
    clearImage();
    drawFrame(-1);
    checkEq("o_valid pulses", validCount, 0);
    drawFrame(-1);
    checkEq("o_valid pulses", validCount, 0);
  endtask

  task automatic firstLock();
    tick();
    i_start = 1'b1;
    tick();
    checkEq("o_isTracking", o_isTracking, 1);
    expOH = (FRAME_H - SEARCH_H) / 2;  // centred region
    expOV = (FRAME_V - SEARCH_V) / 2;
    clearImage();
    drawFrame(-1);  // its frame end arms the first region
    checkEq("o_valid pulses", validCount, 0);
    paintRect(14, 10, 4, 4, BLUE_PIX);
    runSearch();
    checkEq("o_pointH", gotH, 14);
    checkEq("o_pointV", gotV, 10);
  endtask

  task automatic recentring();
    clearImage();
    paintRect(16, 14, 4, 4, BLUE_PIX);  // region at (10,6)
    runSearch();
    clearImage();
    paintRect(12, 10, 4, 4, BLUE_PIX);
    runSearch();
    clearImage();
    paintRect(8, 6, 4, 4, BLUE_PIX);
    runSearch();
    clearImage();
    paintRect(4, 2, 4, 4, BLUE_PIX);    // near the corner so the next origin clamps
    runSearch();
  endtask

  task automatic tieAndNoColour();
    clearImage();
    runSearch();
    checkEq("o_pointH", gotH, 0);  // first window of a clamped region
    checkEq("o_pointV", gotV, 0);
    clearImage();
    paintRect(6, 4, 4, 4, BLUE_PIX);
    paintRect(2, 8, 4, 4, BLUE_PIX);
    runSearch();
    checkEq("o_pointV", gotV, 4);  // upper row finishes first
    clearImage();
    paintRect(4, 4, 4, 4, BLUE_PIX);
    paintRect(8, 4, 4, 4, BLUE_PIX);
    runSearch();
    checkEq("o_pointH", gotH, 4);  // then the left column
  endtask

  task automatic marginsAndRedLoss();
    clearImage();
    paintRect(0, 0, 4, 4, EDGE_BLUE);
    paintRect(9, 8, 2, 2, OVER_BLUE);
    runSearch();
    checkEq("o_pointH", gotH, 8);
    checkEq("o_pointV", gotV, 8);
    clearImage();
    paintRect(6, 4, 4, 4, BLUE_PIX);
    paintRect(10, 8, 2, 2, RED_PIX);  // four red pixels is over the limit
    runSearch();
    checkEq("o_isTracking", gotTrk, 0);
  endtask

  task automatic holdTracking();
    clearImage();
    paintRect(2, 0, 4, 4, BLUE_PIX);  // clean region brings tracking back
    runSearch();
    checkEq("o_isTracking", o_isTracking, 1);
    clearImage();
    paintRect(2, 0, 4, 4, BLUE_PIX);
    drawFrame(40);  // hold early in line 1 while the region is open
    checkEq("o_valid pulses", validCount, 0);
    checkEq("o_isTracking", o_isTracking, 0);
    drawFrame(-1);
    checkEq("o_valid pulses", validCount, 0);
  endtask

  initial begin
    errors       = 0;
    validCount   = 0;
    i_rst_n      = 1'b0;
    i_pixel      = '0;
    i_pixelValid = 1'b0;
    i_start      = 1'b0;
    i_hold       = 1'b0;
    repeat (4) tick();
    i_rst_n = 1'b1;
    tick();
    resetAndIdle();
    firstLock();
    recentring();
    tieAndNoColour();
    marginsAndRedLoss();
    holdTracking();
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

endmodule

/* sim/colorTracker_chk.sv */
module colorTracker_chk #(
  parameter int FRAME_H = 640,
  parameter int FRAME_V = 480
) (
  input logic             i_clk,
  input logic             i_rst_n,
  input logic             i_hold,
  input logic             i_valid,
  input logic             i_isTracking,
  input trackPkg::coord_t i_pointH,
  input trackPkg::coord_t i_pointV
);

  // a result is a single-cycle pulse
  validPulse: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid |=> !i_valid)
    else $error("o_valid high for two cycles in a row");

  holdDrops: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_hold |=> !i_isTracking)
    else $error("o_isTracking still high after i_hold");

  pointInFrame: assert property (@(posedge i_clk) disable iff (!i_rst_n)
    i_valid |-> (i_pointH < FRAME_H) && (i_pointV < FRAME_V))
    else $error("reported point outside the frame");

  validInReset: assert property (@(posedge i_clk) !i_rst_n |-> !i_valid)
    else $error("o_valid high during reset");

endmodule

bind colorTracker colorTracker_chk #(
  .FRAME_H (FRAME_H),
  .FRAME_V (FRAME_V)
) u_chk (
  .i_clk        (i_clk),
  .i_rst_n      (i_rst_n),
  .i_hold       (i_hold),
  .i_valid      (o_valid),
  .i_isTracking (o_isTracking),
  .i_pointH     (o_pointH),
  .i_pointV     (o_pointV)
);

/* hdl/colorTracker.sv */
module colorTracker #(
  parameter int FRAME_H       = 640,
  parameter int FRAME_V       = 480,
  parameter int WIN_H         = 32,
  parameter int WIN_V         = 32,
  parameter int STEP_H        = 16,
  parameter int NUM_WIN       = 7,
  parameter int NUM_ROWS      = 7,
  parameter int BLUE_MARGIN   = 40,
  parameter int RED_MARGIN    = 90,
  parameter int RED_COUNT_MIN = 30
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic [23:0]       i_pixel,
  input  logic              i_pixelValid,
  input  logic              i_start,
  input  logic              i_hold,
  output trackPkg::coord_t  o_pointH,
  output trackPkg::coord_t  o_pointV,
  output logic              o_valid,
  output logic              o_isTracking
);

  trackPkg::color_t color;
  logic             colorValid;
  trackPkg::coord_t col, line;
  logic             frameEnd;
  logic             arm;
  trackPkg::coord_t originH, originV;
  logic             winValid, redFound, regionDone;
  trackPkg::coord_t winH, winV;
  trackPkg::sum_t   blueSum;

  // ==========================================================
  // pixel front end
  // ==========================================================
  pixelClassifier #(
    .BLUE_MARGIN (BLUE_MARGIN),
    .RED_MARGIN  (RED_MARGIN)
  ) u_classifier (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pixel      (i_pixel),
    .i_pixelValid (i_pixelValid),
    .o_color      (color),
    .o_colorValid (colorValid)
  );

  rasterCounter #(
    .FRAME_H (FRAME_H),
    .FRAME_V (FRAME_V)
  ) u_raster (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_pixelValid (i_pixelValid),
    .o_col        (col),
    .o_line       (line),
    .o_frameEnd   (frameEnd)
  );

  // ==========================================================
  // search windows and control
  // ==========================================================
  windowBank #(
    .WIN_H         (WIN_H),
    .WIN_V         (WIN_V),
    .STEP_H        (STEP_H),
    .NUM_WIN       (NUM_WIN),
    .NUM_ROWS      (NUM_ROWS),
    .RED_COUNT_MIN (RED_COUNT_MIN)
  ) u_bank (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_arm        (arm),
    .i_originH    (originH),
    .i_originV    (originV),
    .i_col        (col),
    .i_line       (line),
    .i_color      (color),
    .i_colorValid (colorValid),
    .o_winValid   (winValid),
    .o_winH       (winH),
    .o_winV       (winV),
    .o_blueSum    (blueSum),
    .o_redFound   (redFound),
    .o_regionDone (regionDone)
  );

  trackCtrl #(
    .FRAME_H  (FRAME_H),
    .FRAME_V  (FRAME_V),
    .WIN_H    (WIN_H),
    .WIN_V    (WIN_V),
    .STEP_H   (STEP_H),
    .NUM_WIN  (NUM_WIN),
    .NUM_ROWS (NUM_ROWS)
  ) u_ctrl (
    .i_clk        (i_clk),
    .i_rst_n      (i_rst_n),
    .i_start      (i_start),
    .i_hold       (i_hold),
    .i_frameEnd   (frameEnd),
    .i_winValid   (winValid),
    .i_winH       (winH),
    .i_winV       (winV),
    .i_blueSum    (blueSum),
    .i_redFound   (redFound),
    .i_regionDone (regionDone),
    .o_arm        (arm),
    .o_originH    (originH),
    .o_originV    (originV),
    .o_pointH     (o_pointH),
    .o_pointV     (o_pointV),
    .o_valid      (o_valid),
    .o_isTracking (o_isTracking)
  );

endmodule

/* hdl/trackCtrl.sv */
module trackCtrl #(
  parameter int FRAME_H  = 640,
  parameter int FRAME_V  = 480,
  parameter int WIN_H    = 32,
  parameter int WIN_V    = 32,
  parameter int STEP_H   = 16,
  parameter int NUM_WIN  = 7,
  parameter int NUM_ROWS = 7
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_start,
  input  logic              i_hold,
  input  logic              i_frameEnd,
  input  logic              i_winValid,
  input  trackPkg::coord_t  i_winH,
  input  trackPkg::coord_t  i_winV,
  input  trackPkg::sum_t    i_blueSum,
  input  logic              i_redFound,
  input  logic              i_regionDone,
  output logic              o_arm,
  output trackPkg::coord_t  o_originH,
  output trackPkg::coord_t  o_originV,
  output trackPkg::coord_t  o_pointH,
  output trackPkg::coord_t  o_pointV,
  output logic              o_valid,
  output logic              o_isTracking
);

  localparam int SEARCH_H = STEP_H * (NUM_WIN - 1) + WIN_H;
  localparam int SEARCH_V = NUM_ROWS * WIN_V;
  localparam int CENTER_H = (FRAME_H - SEARCH_H) / 2;  // region centred in frame
  localparam int CENTER_V = (FRAME_V - SEARCH_V) / 2;

  typedef enum logic [1:0] {
    S_IDLE,
    S_WAIT,
    S_SEARCH
  } state_t;

  state_t           state;
  trackPkg::coord_t bestH, bestV;
  trackPkg::sum_t   bestSum;
  logic             haveBest;   // first report of the region seen
  logic             anyRed;
  logic             takeBest;

  // only a strictly larger sum replaces the current best
  assign takeBest = (state == S_SEARCH) && i_winValid && !i_hold
                 && (!haveBest || (i_blueSum > bestSum));

  // ==========================================================
  // tracking FSM
  // ==========================================================
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      state        <= S_IDLE;
      o_arm        <= 1'b0;
      o_valid      <= 1'b0;
      o_isTracking <= 1'b0;
      o_originH    <= trackPkg::coord_t'(CENTER_H);
      o_originV    <= trackPkg::coord_t'(CENTER_V);
      o_pointH     <= '0;
      o_pointV     <= '0;
      haveBest     <= 1'b0;
      anyRed       <= 1'b0;
    end else begin
      o_arm   <= 1'b0;
      o_valid <= 1'b0;
      if (i_hold) begin
        state        <= S_IDLE;   // abandon, late reports are ignored
        o_isTracking <= 1'b0;
      end else begin
        case (state)
          S_IDLE: begin
            if (i_start) begin
              o_originH    <= trackPkg::coord_t'(CENTER_H);
              o_originV    <= trackPkg::coord_t'(CENTER_V);
              o_isTracking <= 1'b1;
              state        <= S_WAIT;
            end
          end
          S_WAIT: begin
            if (i_frameEnd) begin
              o_arm    <= 1'b1;   // next frame starts a fresh region
              haveBest <= 1'b0;
              anyRed   <= 1'b0;
              state    <= S_SEARCH;
            end
          end
          S_SEARCH: begin
            if (i_winValid) begin
              haveBest <= 1'b1;
              anyRed   <= anyRed | i_redFound;
            end
            if (i_regionDone) begin
              o_pointH     <= bestH;
              o_pointV     <= bestV;
              o_valid      <= 1'b1;
              o_isTracking <= !anyRed;
              o_originH    <= trackPkg::clampOrigin(bestH, SEARCH_H, WIN_H, FRAME_H);
              o_originV    <= trackPkg::clampOrigin(bestV, SEARCH_V, WIN_V, FRAME_V);
              state        <= S_WAIT;
            end
          end
          default: state <= S_IDLE;
        endcase
      end
    end
  end

  // best window so far
  always_ff @(posedge i_clk) begin
    if (takeBest) begin
      bestH   <= i_winH;
      bestV   <= i_winV;
      bestSum <= i_blueSum;
    end
  end

endmodule

/* windowBank/windowBank.sv */
module windowBank #(
  parameter int WIN_H         = 32,
  parameter int WIN_V         = 32,
  parameter int STEP_H        = 16,
  parameter int NUM_WIN       = 7,
  parameter int NUM_ROWS      = 7,
  parameter int RED_COUNT_MIN = 30
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_arm,
  input  trackPkg::coord_t  i_originH,
  input  trackPkg::coord_t  i_originV,
  input  trackPkg::coord_t  i_col,
  input  trackPkg::coord_t  i_line,
  input  trackPkg::color_t  i_color,
  input  logic              i_colorValid,
  output logic              o_winValid,
  output trackPkg::coord_t  o_winH,
  output trackPkg::coord_t  o_winV,
  output trackPkg::sum_t    o_blueSum,
  output logic              o_redFound,
  output logic              o_regionDone
);

  localparam int IDX_W = (NUM_WIN > 1) ? $clog2(NUM_WIN) : 1;
  localparam int ROW_W = (NUM_ROWS > 1) ? $clog2(NUM_ROWS) : 1;

  trackPkg::coord_t originH, originV;
  trackPkg::coord_t baseH, baseV;
  trackPkg::coord_t startH [NUM_WIN];
  trackPkg::sum_t   blueSum [NUM_WIN];
  logic [ROW_W-1:0]   row;
  logic               active;
  logic               lastPend;     // last window of the region just went out
  logic [NUM_WIN-1:0] seen;         // windows of this row already reported
  logic [NUM_WIN-1:0] done, redFound, clear, pending, pickMask;
  logic               pickValid, rowComplete;
  logic [IDX_W-1:0]   pickIdx;

  // ==========================================================
  // window geometry
  // ==========================================================
  // new origin takes effect in the arm cycle itself
  assign baseH = i_arm ? i_originH : originH;
  assign baseV = i_arm ? i_originV : trackPkg::coord_t'(originV + row * WIN_V);

  for (genvar k = 0; k < NUM_WIN; k++) begin : g_win
    assign startH[k] = trackPkg::coord_t'(baseH + k * STEP_H);
    assign clear[k]  = i_arm | pickMask[k];

    winAccum #(
      .WIN_H         (WIN_H),
      .WIN_V         (WIN_V),
      .RED_COUNT_MIN (RED_COUNT_MIN)
    ) u_win (
      .i_clk        (i_clk),
      .i_rst_n      (i_rst_n),
      .i_clear      (clear[k]),
      .i_startH     (startH[k]),
      .i_startV     (baseV),
      .i_col        (i_col),
      .i_line       (i_line),
      .i_color      (i_color),
      .i_colorValid (i_colorValid),
      .o_blueSum    (blueSum[k]),
      .o_redFound   (redFound[k]),
      .o_done       (done[k])
    );
  end

  // ==========================================================
  // fixed-priority picker, lowest index first
  // ==========================================================
  assign pending = done & ~seen & {NUM_WIN{active & ~i_arm}};

  always_comb begin
    pickValid = |pending;
    pickIdx   = '0;
    pickMask  = '0;
    for (int k = NUM_WIN - 1; k >= 0; k--) begin
      if (pending[k]) begin
        pickIdx  = IDX_W'(k);
        pickMask = NUM_WIN'(1) << k;
      end
    end
  end

  assign rowComplete = pickValid && (&(seen | pickMask));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      originH      <= '0;
      originV      <= '0;
      row          <= '0;
      seen         <= '0;
      active       <= 1'b0;
      lastPend     <= 1'b0;
      o_winValid   <= 1'b0;
      o_regionDone <= 1'b0;
    end else begin
      o_winValid   <= pickValid;
      o_regionDone <= lastPend && !i_arm;
      lastPend     <= 1'b0;
      if (i_arm) begin
        originH <= i_originH;
        originV <= i_originV;
        row     <= '0;
        seen    <= '0;
        active  <= 1'b1;
      end else if (pickValid) begin
        if (rowComplete) begin
          seen <= '0;
          if (row == ROW_W'(NUM_ROWS - 1)) begin
            active   <= 1'b0;  // idle until the next arm
            lastPend <= 1'b1;
          end else begin
            row <= row + 1'b1;
          end
        end else begin
          seen <= seen | pickMask;
        end
      end
    end
  end

  // report payload
  always_ff @(posedge i_clk) begin
    if (pickValid) begin
      o_winH     <= startH[pickIdx];
      o_winV     <= baseV;
      o_blueSum  <= blueSum[pickIdx];
      o_redFound <= redFound[pickIdx];
    end
  end

endmodule

/* windowBank/winAccum.sv */
module winAccum #(
  parameter int WIN_H         = 32,
  parameter int WIN_V         = 32,
  parameter int RED_COUNT_MIN = 30
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_clear,
  input  trackPkg::coord_t  i_startH,
  input  trackPkg::coord_t  i_startV,
  input  trackPkg::coord_t  i_col,
  input  trackPkg::coord_t  i_line,
  input  trackPkg::color_t  i_color,
  input  logic              i_colorValid,
  output trackPkg::sum_t    o_blueSum,
  output logic              o_redFound,
  output logic              o_done
);

  trackPkg::sum_t blueCnt, redCnt;
  logic           inRect;
  logic           lastPix;
  logic           hitBlue, hitRed;

  assign inRect = i_colorValid
               && (i_col >= i_startH) && (i_col < i_startH + WIN_H)
               && (i_line >= i_startV) && (i_line < i_startV + WIN_V);

  // bottom-right pixel of the rectangle
  assign lastPix = i_colorValid
                && (i_col == i_startH + WIN_H - 1)
                && (i_line == i_startV + WIN_V - 1);

  assign hitBlue = inRect && (i_color == trackPkg::BLUE);
  assign hitRed  = inRect && (i_color == trackPkg::RED);

  // a pixel seen together with the clear still counts
  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      blueCnt <= '0;
      redCnt  <= '0;
      o_done  <= 1'b0;
    end else begin
      blueCnt <= (i_clear ? '0 : blueCnt) + trackPkg::sum_t'(hitBlue);
      redCnt  <= (i_clear ? '0 : redCnt) + trackPkg::sum_t'(hitRed);
      o_done  <= (i_clear ? 1'b0 : o_done) | lastPix;
    end
  end

  assign o_blueSum  = blueCnt;
  assign o_redFound = (redCnt > RED_COUNT_MIN);

endmodule

/* hdl/rasterCounter.sv */
module rasterCounter #(
  parameter int FRAME_H = 640,
  parameter int FRAME_V = 480
) (
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_pixelValid,
  output trackPkg::coord_t  o_col,
  output trackPkg::coord_t  o_line,
  output logic              o_frameEnd
);

  trackPkg::coord_t colCnt;   // position of the next accepted pixel
  trackPkg::coord_t lineCnt;
  logic             lastCol, lastLine;

  assign lastCol  = (colCnt == trackPkg::coord_t'(FRAME_H - 1));
  assign lastLine = (lineCnt == trackPkg::coord_t'(FRAME_V - 1));

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      colCnt     <= '0;
      lineCnt    <= '0;
      o_col      <= '0;
      o_line     <= '0;
      o_frameEnd <= 1'b0;
    end else begin
      o_frameEnd <= i_pixelValid && lastCol && lastLine;
      if (i_pixelValid) begin
        o_col  <= colCnt;   // lines up with the classifier register
        o_line <= lineCnt;
        if (lastCol) begin
          colCnt  <= '0;
          lineCnt <= lastLine ? '0 : lineCnt + 1'b1;
        end else begin
          colCnt <= colCnt + 1'b1;
        end
      end
    end
  end

endmodule

/* hdl/pixelClassifier.sv */
module pixelClassifier #(
  parameter int BLUE_MARGIN = 40,
  parameter int RED_MARGIN  = 90
) (
  input  logic                  i_clk,
  input  logic                  i_rst_n,
  input  logic [23:0]           i_pixel,
  input  logic                  i_pixelValid,
  output trackPkg::color_t      o_color,
  output logic                  o_colorValid
);

  logic [7:0] red, green, blue;
  logic [7:0] bMinusR, bMinusG;
  logic [7:0] rMinusB, rMinusG;
  logic       isBlue, isRed;

  assign {red, green, blue} = i_pixel;

  // saturating channel differences
  assign bMinusR = (blue > red)   ? blue - red   : 8'd0;
  assign bMinusG = (blue > green) ? blue - green : 8'd0;
  assign rMinusB = (red > blue)   ? red - blue   : 8'd0;
  assign rMinusG = (red > green)  ? red - green  : 8'd0;

  // strictly over the margin on both channels
  assign isBlue = (bMinusR > BLUE_MARGIN) && (bMinusG > BLUE_MARGIN);
  assign isRed  = (rMinusB > RED_MARGIN) && (rMinusG > RED_MARGIN);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n)
      o_colorValid <= 1'b0;
    else
      o_colorValid <= i_pixelValid;
  end

  always_ff @(posedge i_clk) begin
    if (i_pixelValid)
      o_color <= isBlue ? trackPkg::BLUE : (isRed ? trackPkg::RED : trackPkg::NONE);
  end

endmodule

/* common/trackPkg.sv */
package trackPkg;

  // ==========================================================
  // coordinate and count types
  // ==========================================================
  parameter int COORD_W = 10;
  parameter int SUM_W   = 12;

  typedef logic [COORD_W-1:0] coord_t;  // pixel column or line
  typedef logic [SUM_W-1:0]   sum_t;    // pixels counted in one window

  // class of one pixel
  typedef enum logic [1:0] {
    NONE = 2'd0,
    BLUE = 2'd1,
    RED  = 2'd2
  } color_t;

  // ==========================================================
  // region recentring
  // ==========================================================
  // puts the best window in the middle of the next region,
  // then keeps the region inside the frame
  function automatic coord_t clampOrigin(
    input coord_t best,
    input int     region,
    input int     win,
    input int     frame
  );
    int pos;
    pos = int'(best) - (region - win) / 2;
    if (pos < 0)
      pos = 0;
    else if (pos > frame - region)
      pos = frame - region;  // region would run off the far edge
    return coord_t'(pos);
  endfunction

endpackage
